//--- source/trace_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared sizes, enums and the retired record of the pipeline trace
// unit. modules import it inside their body and use scoped names in
// their port lists
//////////////////////////////////////////////////////////////////////

package trace_pkg;

    // pipeline geometry
    localparam int STAGES = 5;
    localparam int SEQ_W  = 16;
    localparam int SLOT_W = 3;
    localparam int XLEN   = 32;

    // stage lanes inside the tag bundle
    localparam int ST_FETCH  = 0;
    localparam int ST_DECODE = 1;
    localparam int ST_EXEC   = 2;
    localparam int ST_MEM    = 3;
    localparam int ST_WB     = 4;

    // record FIFO
    localparam int FIFO_DEPTH = 4;
    localparam int CNT_W      = 3;
    localparam int PTR_W      = $clog2(FIFO_DEPTH);

    typedef enum logic [1:0] {
        mem_none  = 2'd0,
        mem_load  = 2'd1,
        mem_store = 2'd2
    } mem_op_t;

    // register map of the bus port
    typedef enum logic [7:0] {
        reg_status = 8'h00,
        reg_seq    = 8'h04,
        reg_pc     = 8'h08,
        reg_instr  = 8'h0C,
        reg_result = 8'h10,
        reg_cycle  = 8'h14
    } reg_addr_t;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axi_resp_t;

    // one retired instruction
    typedef struct packed {
        logic [SEQ_W-1:0] seq;
        logic [XLEN-1:0]  pc;
        logic [XLEN-1:0]  instr;
        logic             flushed;
        logic [XLEN-1:0]  result;
        mem_op_t          mem_op;
        logic [4:0]       rd;
        logic [31:0]      cycle;
    } trace_rec_t;

endpackage

//--- source/stage_tag_if.sv
//////////////////////////////////////////////////////////////////////
// valid bit and storage slot of each pipeline stage, plus the full
// sequence tag at write-back. driven by the tag pipeline
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface stage_tag_if;
    import trace_pkg::*;

    // lane i is stage i, fetch first
    logic [STAGES-1:0] valid;
    logic [SLOT_W-1:0] slot [STAGES];
    logic [SEQ_W-1:0]  wb_seq;

    modport src (output valid, output slot, output wb_seq);

    // fetch and decode writers, read back at write-back
    modport front (input valid, input slot);

    // execute and memory writers, read back at write-back
    modport back (input valid, input slot);

    modport retire (input valid, input wb_seq);

endinterface

//--- source/trace_fifo_if.sv
//////////////////////////////////////////////////////////////////////
// record FIFO status and head toward the bus port, pop back from it.
// a pop on an empty FIFO has no effect
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface trace_fifo_if;
    import trace_pkg::*;

    trace_rec_t       head;
    logic [CNT_W-1:0] count;
    logic [15:0]      dropped;
    // single-cycle strobe
    logic             pop;

    modport fifo (output head, output count, output dropped, input pop);

    modport port (input head, input count, input dropped, output pop);

endinterface

//--- source/tag_pipeline.sv
//////////////////////////////////////////////////////////////////////
// issues a sequence tag for every unstalled fetch and moves tag and
// valid one stage per clock, fetch through write-back
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tag_pipeline (
    input logic      clk,
    input logic      rst,
    input logic      stall,
    stage_tag_if.src tags
);
    import trace_pkg::*;

    logic [STAGES-1:0] valid_q;
    logic [SEQ_W-1:0]  fetch_seq;
    logic [SEQ_W-1:0]  seq_pipe [1:STAGES-1];

    ////////////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////////////

    // fetch lane valid when stall was low at the last edge,
    // every later lane shifts unconditionally so a stall is a bubble
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q   <= '0;
            fetch_seq <= '0;
        end else begin
            valid_q <= {valid_q[STAGES-2:0], ~stall};
            // next tag only after a fetch was taken
            if (valid_q[ST_FETCH]) begin
                fetch_seq <= fetch_seq + 1'b1;
            end
        end
    end

    // tags follow the valids
    always_ff @(posedge clk) begin
        seq_pipe[1] <= fetch_seq;
        for (int i = 2; i < STAGES; i++) begin
            seq_pipe[i] <= seq_pipe[i-1];
        end
    end

    ////////////////////////////////////////////////////////////////////
    // lane outputs
    ////////////////////////////////////////////////////////////////////

    assign tags.valid  = valid_q;
    assign tags.wb_seq = seq_pipe[ST_WB];

    // slot is the low tag bits
    always_comb begin
        tags.slot[ST_FETCH] = fetch_seq[SLOT_W-1:0];
        for (int i = 1; i < STAGES; i++) begin
            tags.slot[i] = seq_pipe[i][SLOT_W-1:0];
        end
    end

endmodule

//--- source/front_capture.sv
//////////////////////////////////////////////////////////////////////
// front half of the trace. fetch PC, instruction word and flush flag
// stored under the tag slot, read back when the tag hits write-back
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module front_capture (
    input  logic                       clk,
    input  logic                       rst,
    stage_tag_if.front                 tags,
    input  logic [trace_pkg::XLEN-1:0] fetch_pc,
    input  logic [trace_pkg::XLEN-1:0] decode_instr,
    input  logic                       decode_flush,
    output logic [trace_pkg::XLEN-1:0] pc_out,
    output logic [trace_pkg::XLEN-1:0] instr_out,
    output logic                       flushed_out
);
    import trace_pkg::*;

    // one entry per slot
    logic [XLEN-1:0]        pc_mem    [2**SLOT_W];
    logic [XLEN-1:0]        instr_mem [2**SLOT_W];
    logic [2**SLOT_W-1:0]   flush_mem;

    // sampled at the edge closing the valid cycle
    always_ff @(posedge clk) begin
        if (tags.valid[ST_FETCH]) begin
            pc_mem[tags.slot[ST_FETCH]] <= fetch_pc;
        end
        if (tags.valid[ST_DECODE]) begin
            instr_mem[tags.slot[ST_DECODE]] <= decode_instr;
        end
    end

    // flush flags start clear
    always_ff @(posedge clk) begin
        if (rst) begin
            flush_mem <= '0;
        end else if (tags.valid[ST_DECODE]) begin
            flush_mem[tags.slot[ST_DECODE]] <= decode_flush;
        end
    end

    // write-back readout, same cycle
    assign pc_out      = pc_mem[tags.slot[ST_WB]];
    assign instr_out   = instr_mem[tags.slot[ST_WB]];
    assign flushed_out = flush_mem[tags.slot[ST_WB]];

endmodule

//--- source/back_capture.sv
//////////////////////////////////////////////////////////////////////
// back half of the trace. execute result and memory operation kind
// stored under the tag slot, read back at write-back. the destination
// register is taken at write-back itself by the retire block
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module back_capture (
    input  logic                       clk,
    input  logic                       rst,
    stage_tag_if.back                  tags,
    input  logic [trace_pkg::XLEN-1:0] execute_result,
    input  trace_pkg::mem_op_t         mem_op,
    output logic [trace_pkg::XLEN-1:0] result_out,
    output trace_pkg::mem_op_t         mem_op_out
);
    import trace_pkg::*;

    logic [XLEN-1:0] result_mem [2**SLOT_W];
    mem_op_t         memop_mem  [2**SLOT_W];

    // result lands one stage before the memory kind
    always_ff @(posedge clk) begin
        if (tags.valid[ST_EXEC]) begin
            result_mem[tags.slot[ST_EXEC]] <= execute_result;
        end
    end

    // memory kind, no access after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**SLOT_W; i++) begin
                memop_mem[i] <= mem_none;
            end
        end else if (tags.valid[ST_MEM]) begin
            memop_mem[tags.slot[ST_MEM]] <= mem_op;
        end
    end

    assign result_out = result_mem[tags.slot[ST_WB]];
    assign mem_op_out = memop_mem[tags.slot[ST_WB]];

endmodule

//--- source/retire_assembler.sv
//////////////////////////////////////////////////////////////////////
// builds the retired record in the write-back cycle from both
// captures, stamps the cycle count and queues it in the record FIFO.
// records that find the FIFO full are counted as dropped
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module retire_assembler (
    input  logic                       clk,
    input  logic                       rst,
    stage_tag_if.retire                tags,
    input  logic [trace_pkg::XLEN-1:0] pc,
    input  logic [trace_pkg::XLEN-1:0] instr,
    input  logic                       flushed,
    input  logic [trace_pkg::XLEN-1:0] result,
    input  trace_pkg::mem_op_t         mem_op,
    input  logic [4:0]                 wb_rd,
    trace_fifo_if.fifo                 fifo
);
    import trace_pkg::*;

    logic [31:0]      cycle_q;
    trace_rec_t       rec;
    trace_rec_t       rec_mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [15:0]      dropped;
    logic             full;
    logic             push;
    logic             pop_ok;

    // free-running retire clock
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_q <= '0;
        end else begin
            cycle_q <= cycle_q + 1'b1;
        end
    end

    // record of the tag now in write-back
    always_comb begin
        rec.seq     = tags.wb_seq;
        rec.pc      = pc;
        rec.instr   = instr;
        rec.flushed = flushed;
        rec.result  = result;
        rec.mem_op  = mem_op;
        rec.rd      = wb_rd;
        rec.cycle   = cycle_q;
    end

    ////////////////////////////////////////////////////////////////////
    // record FIFO
    ////////////////////////////////////////////////////////////////////

    assign full   = (count == CNT_W'(FIFO_DEPTH));
    assign push   = tags.valid[ST_WB] && !full;
    assign pop_ok = fifo.pop && (count != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            rec_mem[wr_ptr] <= rec;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            dropped <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop_ok);
            // full FIFO loses the record, counter sticks at max
            if (tags.valid[ST_WB] && full && dropped != 16'hFFFF) begin
                dropped <= dropped + 1'b1;
            end
        end
    end

    assign fifo.head    = rec_mem[rd_ptr];
    assign fifo.count   = count;
    assign fifo.dropped = dropped;

endmodule

//--- source/axil_trace_port.sv
//////////////////////////////////////////////////////////////////////
// AXI4-Lite slave for the trace FIFO. reads return status or a field
// of the head record, a write to the status register pops the head.
// one transaction per channel at a time
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module axil_trace_port (
    input  logic                       clk,
    input  logic                       rst,
    // write address and data
    input  logic [7:0]                 awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [trace_pkg::XLEN-1:0] wdata,
    input  logic                       wvalid,
    output logic                       wready,
    // write response
    output trace_pkg::axi_resp_t       bresp,
    output logic                       bvalid,
    input  logic                       bready,
    // read address
    input  logic [7:0]                 araddr,
    input  logic                       arvalid,
    output logic                       arready,
    // read data
    output logic [trace_pkg::XLEN-1:0] rdata,
    output trace_pkg::axi_resp_t       rresp,
    output logic                       rvalid,
    input  logic                       rready,
    trace_fifo_if.port                 fifo
);
    import trace_pkg::*;

    logic            wr_hs;
    logic            rd_hs;
    trace_rec_t      head;
    logic [XLEN-1:0] rd_word;
    axi_resp_t       rd_resp;

    function automatic logic addr_mapped(input logic [7:0] addr);
        case (addr)
            reg_status, reg_seq, reg_pc, reg_instr, reg_result, reg_cycle: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////
    // write channel
    ////////////////////////////////////////////////////////////////////

    // address and data taken together, never while a response waits
    assign wr_hs   = awvalid && wvalid && !bvalid;
    assign awready = wr_hs;
    assign wready  = wr_hs;

    // data word is don't-care, every status write pops
    assign fifo.pop = wr_hs && (awaddr == reg_status);

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            bresp  <= resp_okay;
        end else if (wr_hs) begin
            bvalid <= 1'b1;
            bresp  <= addr_mapped(awaddr) ? resp_okay : resp_slverr;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // read channel
    ////////////////////////////////////////////////////////////////////

    assign arready = !rvalid;
    assign rd_hs   = arvalid && arready;

    // empty FIFO shows an all-zero record
    always_comb begin
        head    = (fifo.count == '0) ? '0 : fifo.head;
        rd_word = '0;
        rd_resp = resp_okay;
        case (araddr)
            reg_status: rd_word = {fifo.dropped, {(16-CNT_W){1'b0}}, fifo.count};
            reg_seq:    rd_word = {3'd0, head.rd, 5'd0, head.mem_op, head.flushed, head.seq};
            reg_pc:     rd_word = head.pc;
            reg_instr:  rd_word = head.instr;
            reg_result: rd_word = head.result;
            reg_cycle:  rd_word = head.cycle;
            default:    rd_resp = resp_slverr;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (rd_hs) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // read payload, held while rvalid waits
    always_ff @(posedge clk) begin
        if (rd_hs) begin
            rdata <= rd_word;
            rresp <= rd_resp;
        end
    end

endmodule

//--- source/pipe_trace_top.sv
//////////////////////////////////////////////////////////////////////
// top of the pipeline trace unit. CPU stage observations in, retired
// records out over AXI4-Lite. fetch_take marks the cycle in which the
// CPU side must present fetch_pc
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pipe_trace_top (
    input  logic                       clk,
    input  logic                       rst,
    // CPU side
    input  logic                       stall,
    output logic                       fetch_take,
    input  logic [trace_pkg::XLEN-1:0] fetch_pc,
    input  logic [trace_pkg::XLEN-1:0] decode_instr,
    input  logic                       decode_flush,
    input  logic [trace_pkg::XLEN-1:0] execute_result,
    input  trace_pkg::mem_op_t         mem_op,
    input  logic [4:0]                 wb_rd,
    // AXI4-Lite slave
    input  logic [7:0]                 awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [trace_pkg::XLEN-1:0] wdata,
    input  logic                       wvalid,
    output logic                       wready,
    output trace_pkg::axi_resp_t       bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  logic [7:0]                 araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [trace_pkg::XLEN-1:0] rdata,
    output trace_pkg::axi_resp_t       rresp,
    output logic                       rvalid,
    input  logic                       rready
);
    import trace_pkg::*;

    stage_tag_if  tags ();
    trace_fifo_if trace_q ();

    // write-back readouts of the two captures
    logic [XLEN-1:0] wb_pc;
    logic [XLEN-1:0] wb_instr;
    logic            wb_flushed;
    logic [XLEN-1:0] wb_result;
    mem_op_t         wb_mem_op;

    assign fetch_take = tags.valid[ST_FETCH];

    tag_pipeline u_tags (
        .clk   (clk),
        .rst   (rst),
        .stall (stall),
        .tags  (tags.src)
    );

    front_capture u_front (
        .clk          (clk),
        .rst          (rst),
        .tags         (tags.front),
        .fetch_pc     (fetch_pc),
        .decode_instr (decode_instr),
        .decode_flush (decode_flush),
        .pc_out       (wb_pc),
        .instr_out    (wb_instr),
        .flushed_out  (wb_flushed)
    );

    back_capture u_back (
        .clk            (clk),
        .rst            (rst),
        .tags           (tags.back),
        .execute_result (execute_result),
        .mem_op         (mem_op),
        .result_out     (wb_result),
        .mem_op_out     (wb_mem_op)
    );

    // rd goes in directly, it is observed at write-back
    retire_assembler u_retire (
        .clk     (clk),
        .rst     (rst),
        .tags    (tags.retire),
        .pc      (wb_pc),
        .instr   (wb_instr),
        .flushed (wb_flushed),
        .result  (wb_result),
        .mem_op  (wb_mem_op),
        .wb_rd   (wb_rd),
        .fifo    (trace_q.fifo)
    );

    axil_trace_port u_axil (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .fifo    (trace_q.port)
    );

endmodule

//--- tests/tb_pipe_trace.sv
//////////////////////////////////////////////////////////////////////
// testbench for the pipeline trace unit. a row table drives stall,
// flush and memory kind, a tag model feeds each stage in its cycle
// and predicts every retired record, read back over AXI4-Lite
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_pipe_trace;
    import trace_pkg::*;

    typedef struct packed {
        logic    stall;
        logic    flush;
        mem_op_t op;
        // drain the pipe and empty the FIFO after this row
        logic    drain;
    } row_t;

    localparam int NROWS = 17;
    localparam int CYCLE_LIMIT = NROWS * 20 + 200;

    // back to back with one flush, then stall bubbles, then overflow
    localparam row_t TBL [NROWS] = '{
        '{1'b0, 1'b0, mem_none,  1'b0}, '{1'b0, 1'b0, mem_load,  1'b0},
        '{1'b0, 1'b1, mem_store, 1'b0}, '{1'b0, 1'b0, mem_none,  1'b1},
        '{1'b0, 1'b0, mem_load,  1'b0}, '{1'b1, 1'b0, mem_none,  1'b0},
        '{1'b1, 1'b0, mem_none,  1'b0}, '{1'b0, 1'b1, mem_none,  1'b0},
        '{1'b1, 1'b0, mem_none,  1'b0}, '{1'b0, 1'b0, mem_store, 1'b1},
        '{1'b0, 1'b0, mem_load,  1'b0}, '{1'b0, 1'b0, mem_store, 1'b0},
        '{1'b0, 1'b1, mem_none,  1'b0}, '{1'b0, 1'b0, mem_load,  1'b0},
        '{1'b0, 1'b0, mem_none,  1'b0}, '{1'b0, 1'b0, mem_store, 1'b0},
        '{1'b0, 1'b0, mem_load,  1'b1}
    };

    logic            clk;
    logic            rst;
    logic            stall;
    logic            fetch_take;
    logic [XLEN-1:0] fetch_pc;
    logic [XLEN-1:0] decode_instr;
    logic            decode_flush;
    logic [XLEN-1:0] execute_result;
    mem_op_t         mem_op;
    logic [4:0]      wb_rd;
    logic [7:0]      awaddr;
    logic            awvalid;
    logic            awready;
    logic [XLEN-1:0] wdata;
    logic            wvalid;
    logic            wready;
    axi_resp_t       bresp;
    logic            bvalid;
    logic            bready;
    logic [7:0]      araddr;
    logic            arvalid;
    logic            arready;
    logic [XLEN-1:0] rdata;
    axi_resp_t       rresp;
    logic            rvalid;
    logic            rready;

    // row fields that go with the stall value just driven
    logic            row_flush;
    mem_op_t         row_op;

    // tag model state for the current cycle
    logic [4:0]      m_valid;
    logic [SEQ_W-1:0] m_tag [STAGES];
    logic [SEQ_W-1:0] m_fseq;
    logic [31:0]     m_cyc;
    logic [15:0]     m_dropped;
    trace_rec_t      exp_q [$];

    // per-tag stimulus under the low tag bits
    logic [XLEN-1:0] pc_t     [256];
    logic [XLEN-1:0] instr_t  [256];
    logic [XLEN-1:0] res_t    [256];
    logic [4:0]      rd_t     [256];
    logic            flush_t  [256];
    mem_op_t         op_t     [256];

    logic [31:0]     lcg_state;
    int              cycles;

    pipe_trace_top UUT (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    ////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////

    task automatic fail_value(input string name, input logic [63:0] exp_v,
                              input logic [63:0] act_v);
        $display("[ERROR] %0t ns %s expected %0h got %0h", $time, name, exp_v, act_v);
        $display("sim failed");
        $fatal(1, "value mismatch");
    endtask

    task automatic check_word(input string name, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
        if (act_v !== exp_v) begin
            fail_value(name, 64'(exp_v), 64'(act_v));
        end
    endtask

    task automatic check_resp(input string name, input axi_resp_t exp_v,
                              input axi_resp_t act_v);
        if (act_v !== exp_v) begin
            fail_value(name, 64'(exp_v), 64'(act_v));
        end
    endtask

    task automatic check_rec(input trace_rec_t exp_v, input trace_rec_t act_v);
        check_word("rec.seq", 32'(exp_v.seq), 32'(act_v.seq));
        check_word("rec.pc", exp_v.pc, act_v.pc);
        check_word("rec.instr", exp_v.instr, act_v.instr);
        check_word("rec.flushed", 32'(exp_v.flushed), 32'(act_v.flushed));
        check_word("rec.result", exp_v.result, act_v.result);
        check_word("rec.mem_op", 32'(exp_v.mem_op), 32'(act_v.mem_op));
        check_word("rec.rd", 32'(exp_v.rd), 32'(act_v.rd));
        check_word("rec.cycle", exp_v.cycle, act_v.cycle);
    endtask

    ////////////////////////////////////////////////////////////////////
    // AXI4-Lite master
    ////////////////////////////////////////////////////////////////////

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                            output axi_resp_t resp);
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        do @(negedge clk); while (!arready);
        @(posedge clk);
        arvalid <= 1'b0;
        rready  <= 1'b1;
        do @(negedge clk); while (!rvalid);
        // no new address taken while the response waits
        check_word("arready", 32'd0, {31'd0, arready});
        data = rdata;
        resp = rresp;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             output axi_resp_t resp);
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        do @(negedge clk); while (!(awready && wready));
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        bready  <= 1'b1;
        do @(negedge clk); while (!bvalid);
        resp = bresp;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    // head record read one field at a time
    task automatic read_head(output trace_rec_t rec);
        logic [31:0] d;
        axi_resp_t   r;
        rec = '0;
        axi_read(reg_seq, d, r);
        check_resp("rresp", resp_okay, r);
        rec.seq     = d[15:0];
        rec.flushed = d[16];
        rec.mem_op  = mem_op_t'(d[18:17]);
        rec.rd      = d[28:24];
        axi_read(reg_pc, d, r);
        rec.pc = d;
        axi_read(reg_instr, d, r);
        rec.instr = d;
        axi_read(reg_result, d, r);
        rec.result = d;
        axi_read(reg_cycle, d, r);
        rec.cycle = d;
    endtask

    task automatic check_status();
        logic [31:0] d;
        axi_resp_t   r;
        axi_read(reg_status, d, r);
        check_resp("rresp", resp_okay, r);
        check_word("status", {m_dropped, 13'd0, 3'(exp_q.size())}, d);
    endtask

    // stop fetching, wait out the pipe, then pop and compare every record
    task automatic drain_and_check();
        trace_rec_t act;
        trace_rec_t exp_rec;
        axi_resp_t  r;
        @(posedge clk);
        stall <= 1'b1;
        do @(negedge clk); while (m_valid != '0);
        check_status();
        while (exp_q.size() != 0) begin
            read_head(act);
            exp_rec = exp_q.pop_front();
            check_rec(exp_rec, act);
            axi_write(reg_status, 32'h0, r);
            check_resp("bresp", resp_okay, r);
        end
        check_status();
    endtask

    ////////////////////////////////////////////////////////////////////
    // tag model stepping on the same edge as the DUT
    ////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        trace_rec_t rec;
        logic [7:0] t;
        if (rst) begin
            m_valid = '0;
            m_fseq  = '0;
            m_cyc   = '0;
        end else begin
            for (int i = STAGES - 1; i > 0; i--) begin
                m_valid[i] = m_valid[i-1];
                m_tag[i]   = m_tag[i-1];
            end
            // next tag only after a taken fetch
            if (m_valid[0]) begin
                m_fseq = m_fseq + 16'd1;
            end
            m_valid[0] = ~stall;
            m_cyc      = m_cyc + 32'd1;
        end
        m_tag[0] = m_fseq;
        // fresh stimulus for a newly fetched tag
        if (m_valid[0]) begin
            t          = m_tag[0][7:0];
            pc_t[t]    = next_random();
            instr_t[t] = next_random();
            res_t[t]   = next_random();
            rd_t[t]    = 5'(next_random() >> 27);
            flush_t[t] = row_flush;
            op_t[t]    = row_op;
        end
        // each stage gets its own tag data or junk when idle
        fetch_pc       <= m_valid[0] ? pc_t[m_tag[0][7:0]] : 32'hbad0_bad0;
        decode_instr   <= m_valid[1] ? instr_t[m_tag[1][7:0]] : 32'hbad1_bad1;
        decode_flush   <= m_valid[1] ? flush_t[m_tag[1][7:0]] : 1'b1;
        execute_result <= m_valid[2] ? res_t[m_tag[2][7:0]] : 32'hbad2_bad2;
        mem_op         <= m_valid[3] ? op_t[m_tag[3][7:0]] : mem_load;
        wb_rd          <= m_valid[4] ? rd_t[m_tag[4][7:0]] : 5'h1f;
        // expected record in the write-back cycle
        if (m_valid[4]) begin
            t           = m_tag[4][7:0];
            rec.seq     = m_tag[4];
            rec.pc      = pc_t[t];
            rec.instr   = instr_t[t];
            rec.flushed = flush_t[t];
            rec.result  = res_t[t];
            rec.mem_op  = op_t[t];
            rec.rd      = rd_t[t];
            rec.cycle   = m_cyc;
            if (exp_q.size() < FIFO_DEPTH) begin
                exp_q.push_back(rec);
            end else if (m_dropped != 16'hFFFF) begin
                m_dropped = m_dropped + 16'd1;
            end
        end
    end

    // fetch_take against the model at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            check_word("fetch_take", {31'd0, m_valid[0]}, {31'd0, fetch_take});
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("sim failed");
            $fatal(1, "timeout");
        end
    end

    ////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] d;
        axi_resp_t   r;
        clk = 1'b0;
        rst = 1'b1;
        stall = 1'b1;
        row_flush = 1'b0;
        row_op = mem_none;
        fetch_pc = '0;
        decode_instr = '0;
        decode_flush = 1'b0;
        execute_result = '0;
        mem_op = mem_none;
        wb_rd = '0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        m_valid = '0;
        m_fseq = '0;
        m_cyc = '0;
        m_dropped = '0;
        lcg_state = 32'h9b2888ed;
        cycles = 0;
        for (int i = 0; i < STAGES; i++) begin
            m_tag[i] = '0;
        end

        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // bus idle after reset while stall is still high
        repeat (3) @(negedge clk);
        check_word("bvalid", 32'd0, {31'd0, bvalid});
        check_word("rvalid", 32'd0, {31'd0, rvalid});
        check_word("arready", 32'd1, {31'd0, arready});
        check_word("awready", 32'd0, {31'd0, awready});
        check_word("wready", 32'd0, {31'd0, wready});
        check_status();

        for (int i = 0; i < NROWS; i++) begin
            @(posedge clk);
            stall     <= TBL[i].stall;
            row_flush <= TBL[i].flush;
            row_op    <= TBL[i].op;
            if (TBL[i].drain) begin
                drain_and_check();
            end
        end

        // unmapped and empty reads
        axi_read(8'h18, d, r);
        check_resp("rresp", resp_slverr, r);
        check_word("rdata", 32'd0, d);
        axi_write(8'h1C, 32'h0000_1234, r);
        check_resp("bresp", resp_slverr, r);
        axi_read(reg_pc, d, r);
        check_resp("rresp", resp_okay, r);
        check_word("rdata", 32'd0, d);
        check_status();

        $display("sim passed");
        $finish;
    end

endmodule

//--- filelist.f
source/trace_pkg.sv
source/stage_tag_if.sv
source/trace_fifo_if.sv
source/tag_pipeline.sv
source/front_capture.sv
source/back_capture.sv
source/retire_assembler.sv
source/axil_trace_port.sv
source/pipe_trace_top.sv
tests/tb_pipe_trace.sv

//--- Makefile
# Verilator build of the pipeline trace testbench

SIM      := verilator
TOP      := tb_pipe_trace
FILELIST := filelist.f
OBJ_DIR  := obj_dir
FLAGS    := --binary --timing -j 0 --top-module $(TOP)
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

# build the simulation executable
compile:
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status is nonzero when the testbench ends in $fatal
run: compile
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
